// File: all.f
+incdir+logic
logic/cacheGeomPkg.sv
logic/busCtrlPkg.sv
logic/cacheArrayIf.sv
logic/memReqIf.sv
logic/cacheArray.sv
logic/cacheController.sv
logic/apbRequester.sv
logic/dataCacheTop.sv
bench/apbMemModel.sv
bench/dataCacheTb.sv

// File: bench/apbMemModel.sv
`timescale 1ns/10ps

module apbMemModel (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input cacheGeomPkg::addrT paddr,
    input cacheGeomPkg::dataT pwdata,
    input cacheGeomPkg::maskT pstrb,
    output cacheGeomPkg::dataT prdata,
    output logic pready,
    output logic pslverr,
    output int xferCount
);
    import cacheGeomPkg::*;

    dataT mem [addrT];  // sparse, unwritten words read as the fill pattern
    int unsigned lcg;
    logic [1:0] waitCnt;

    function automatic dataT wordAt(addrT a);
        return mem.exists(a) ? mem[a] : {~a, a ^ 32'h3C5A_96E1};
    endfunction

    function automatic int unsigned nextLcg(int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    assign pready = psel && penable && (waitCnt == 2'd0);
    assign pslverr = pready && (paddr[31:28] == 4'hF);  // error region

    always @(posedge clk) begin
        dataT word;
        if (rst) begin
            lcg = 51;
            waitCnt <= 2'd0;
            xferCount <= 0;
        end else if (psel && !penable) begin
            lcg = nextLcg(lcg);
            waitCnt <= lcg[17:16];  // 0 to 3 wait states
            prdata <= wordAt(paddr);
        end else if (waitCnt != 2'd0) begin
            waitCnt <= waitCnt - 2'd1;
        end else if (pready) begin
            xferCount <= xferCount + 1;
            if (pwrite && !pslverr) begin
                word = wordAt(paddr);
                for (int b = 0; b < $bits(maskT); b++) begin
                    if (pstrb[b]) word[8*b +: 8] = pwdata[8*b +: 8];
                end
                mem[paddr] = word;
            end
        end
    end

endmodule

// File: bench/dataCacheTb.sv
`timescale 1ns/10ps

`include "cache_defines.svh"

module dataCacheTb;
    import cacheGeomPkg::*;

    typedef struct packed {
        logic write;
        addrT addr;
        dataT data;
        maskT mask;
        logic xfer;  // APB transfer expected
    } entryT;

    logic clk, rst;
    logic reqValid, reqWrite, reqReady, respValid, respError;
    addrT reqAddr, paddr;
    dataT reqWData, respRData, pwdata, prdata;
    maskT reqMask, pstrb;
    logic psel, penable, pwrite, pready, pslverr;
    int xferCount;

    entryT tbl [16] = '{
        '{1'b0, 32'h0000_0108, 64'h0, 8'h00, 1'b1},  // cold miss
        '{1'b0, 32'h0000_0108, 64'h0, 8'h00, 1'b0},
        '{1'b1, 32'h0000_0108, 64'h1122_3344_5566_7788, 8'h0F, 1'b1},  // store hit
        '{1'b0, 32'h0000_0108, 64'h0, 8'h00, 1'b0},
        '{1'b1, 32'h0000_0210, 64'hDEAD_BEEF_0BAD_F00D, 8'hC3, 1'b1},  // no allocate
        '{1'b0, 32'h0000_0210, 64'h0, 8'h00, 1'b1},
        '{1'b0, 32'h0000_0000, 64'h0, 8'h00, 1'b1},  // three tags in set 0
        '{1'b0, 32'h0000_0020, 64'h0, 8'h00, 1'b1},
        '{1'b0, 32'h0000_0040, 64'h0, 8'h00, 1'b1},  // evicts 0x000
        '{1'b0, 32'h0000_0020, 64'h0, 8'h00, 1'b0},
        '{1'b0, 32'h0000_0000, 64'h0, 8'h00, 1'b1},  // evicts 0x020
        '{1'b0, 32'h0000_0020, 64'h0, 8'h00, 1'b1},  // evicts 0x040
        '{1'b0, 32'h0000_0000, 64'h0, 8'h00, 1'b0},
        '{1'b0, 32'hF000_0008, 64'h0, 8'h00, 1'b1},  // error region
        '{1'b0, 32'hF000_0008, 64'h0, 8'h00, 1'b1},
        '{1'b1, 32'hF000_0010, 64'h0123_4567_89AB_CDEF, 8'hFF, 1'b1}
    };

    dataT shadow [addrT];  // written words, the rest hold the fill pattern
    logic trkValid [`NUM_SETS][`NUM_WAYS] = '{default: 1'b0};
    tagT trkTag [`NUM_SETS][`NUM_WAYS];
    logic trkVictim [`NUM_SETS] = '{default: 1'b0};
    int errors = 0;
    int checks = 0;
    int writeCount = 0;
    logic timedOut = 1'b0;

    dataCacheTop u_dut (.*);
    apbMemModel u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        if (psel && penable && pready && pwrite) writeCount++;  // completed APB writes
    end

    task automatic checkEq(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic applyEntry(input entryT e);
        int tries;
        int xferBefore;
        int writesBefore;
        logic [1:0] idx;
        logic expHit;
        logic expErr;
        dataT expWord;
        idx = e.addr[4:3];
        expHit = 1'b0;
        for (int w = 0; w < `NUM_WAYS; w++) begin
            if (!e.write && trkValid[idx][w] && trkTag[idx][w] == e.addr[31:5]) expHit = 1'b1;
        end
        expErr = (e.addr[31:28] == 4'hF);
        expWord = shadow.exists(e.addr) ? shadow[e.addr] : {~e.addr, e.addr ^ 32'h3C5A_96E1};
        checkEq("table transfer flag", e.xfer, !expHit);
        @(posedge clk);
        #2;
        reqValid = 1'b1;
        reqWrite = e.write;
        reqAddr = e.addr;
        reqWData = e.data;
        reqMask = e.mask;
        tries = 0;
        while (!reqReady && tries < 200) begin
            @(negedge clk);
            tries++;
        end
        if (!reqReady) begin
            errors++;
            timedOut = 1'b1;
            $display("timeout: reqReady stayed low for 200 cycles at %0t", $time);
            return;
        end
        xferBefore = xferCount;
        writesBefore = writeCount;
        @(posedge clk);  // acceptance edge
        #2;
        reqValid = 1'b0;
        tries = 0;
        while (!respValid && tries < 200) begin
            @(negedge clk);
            tries++;
        end
        if (!respValid) begin
            errors++;
            timedOut = 1'b1;
            $display("timeout: no response within 200 cycles at %0t", $time);
            return;
        end
        checkEq("respError", respError, expErr);
        checkEq("APB transfers", xferCount - xferBefore, e.xfer);
        checkEq("APB writes", writeCount - writesBefore, e.write);
        if (!e.write && !expErr) checkEq("load data", respRData, expWord);
        if (expHit) checkEq("hit latency", tries, 2);
        if (e.write && !expErr) begin
            for (int b = 0; b < `BYTES_W; b++) begin
                if (e.mask[b]) expWord[8*b +: 8] = e.data[8*b +: 8];
            end
            shadow[e.addr] = expWord;
        end else if (!e.write && !expHit && !expErr) begin
            trkValid[idx][trkVictim[idx]] = 1'b1;  // miss fills the victim way
            trkTag[idx][trkVictim[idx]] = e.addr[31:5];
            trkVictim[idx] = !trkVictim[idx];
        end
    endtask

    initial begin
        rst = 1'b1;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqAddr = '0;
        reqWData = '0;
        reqMask = '0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        checkEq("reqReady after reset", reqReady, 1'b1);
        checkEq("psel after reset", psel, 1'b0);
        checkEq("respValid after reset", respValid, 1'b0);
        for (int i = 0; i < 16 && !timedOut; i++) begin
            applyEntry(tbl[i]);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: logic/apbRequester.sv
`timescale 1ns/10ps

module apbRequester (
    input logic clk,
    input logic rst,
    memReqIf.server mem,
    output logic psel,
    output logic penable,
    output logic pwrite,
    output cacheGeomPkg::addrT paddr,
    output cacheGeomPkg::dataT pwdata,
    output cacheGeomPkg::maskT pstrb,
    input cacheGeomPkg::dataT prdata,
    input logic pready,
    input logic pslverr
);
    import busCtrlPkg::*;

    apbStateT state;

    assign psel = (state != apbIdle);
    assign penable = (state == apbAccess);

    assign mem.done = penable && pready;
    assign mem.rdata = prdata;
    assign mem.error = mem.done && (apbRespT'(pslverr) == respSlvErr);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= apbIdle;
        end else begin
            case (state)
                apbIdle: if (mem.valid) state <= apbSetup;
                apbSetup: state <= apbAccess;
                apbAccess: if (pready) state <= apbIdle;  // wait states stretch ACCESS
                default: state <= apbIdle;
            endcase
        end
    end

    // outputs settle on the edge into SETUP and hold through ACCESS
    always_ff @(posedge clk) begin
        if (state == apbIdle && mem.valid) begin
            pwrite <= mem.write;
            paddr <= mem.addr;
            pwdata <= mem.wdata;
            pstrb <= mem.write ? mem.strb : '0;  // reads carry no strobes
        end
    end

    accessAfterSetup: assert property (@(posedge clk) disable iff (rst)
        penable |-> (psel && $past(psel)))
        else $error("ACCESS without a preceding SETUP");

    stableAccess: assert property (@(posedge clk) disable iff (rst)
        (psel && !(penable && pready)) |=> ($stable(paddr) && $stable(pwrite)))
        else $error("paddr or pwrite changed during a transfer");

endmodule

// File: logic/busCtrlPkg.sv
package busCtrlPkg;

    typedef enum logic [1:0] {
        ctrlIdle,
        ctrlCheck,
        ctrlMemWait,  // waiting on the APB requester
        ctrlRespond
    } ctrlStateT;

    typedef enum logic [1:0] {
        apbIdle,
        apbSetup,
        apbAccess
    } apbStateT;

    // pslverr encoding
    typedef enum logic {respOkay = 1'b0, respSlvErr = 1'b1} apbRespT;

endpackage

// File: logic/cacheArray.sv
`timescale 1ns/10ps

`include "cache_defines.svh"

module cacheArray (
    input logic clk,
    input logic rst,
    cacheArrayIf.array bus
);
    import cacheGeomPkg::*;

    dataT dataMem [`NUM_WAYS][`NUM_SETS];
    tagT tagMem [`NUM_WAYS][`NUM_SETS];
    logic [`NUM_WAYS-1:0] validBits [`NUM_SETS];
    logic [`NUM_SETS-1:0] victim;  // way to replace next, per set

    indexT idx;
    tagT tag;
    logic [`NUM_WAYS-1:0] wayHit;
    wayT fillWay;

    assign idx = bus.lookupAddr[offW +: idxW];
    assign tag = bus.lookupAddr[`ADDR_W-1 -: tagW];

    always_comb begin
        for (int w = 0; w < `NUM_WAYS; w++) begin
            wayHit[w] = validBits[idx][w] && (tagMem[w][idx] == tag);
        end
    end

    assign bus.hit = |wayHit;
    assign bus.hitWay = wayT'(wayHit[1]);
    assign bus.hitData = bus.hit ? dataMem[bus.hitWay][idx] : '0;

    // reuse a matching line, else take the victim
    assign fillWay = bus.hit ? bus.hitWay : wayT'(victim[idx]);

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '{default: '0};
            victim <= '0;
        end else if (bus.refill) begin
            validBits[idx][fillWay] <= 1'b1;
            victim[idx] <= ~victim[idx];  // toggles on every fill
        end
    end

    always_ff @(posedge clk) begin
        if (bus.refill) begin
            dataMem[fillWay][idx] <= bus.refillData;
            tagMem[fillWay][idx] <= tag;
        end else if (bus.store && bus.hit) begin
            for (int b = 0; b < `BYTES_W; b++) begin
                if (bus.storeMask[b]) begin
                    dataMem[bus.hitWay][idx][8*b +: 8] <= bus.storeData[8*b +: 8];
                end
            end
        end
    end

    // a fill never lands a duplicate tag in the other way
    singleHit: assert property (@(posedge clk) disable iff (rst)
        !(wayHit[0] && wayHit[1]))
        else $error("both ways hit at set %0d", idx);

    strobeExclusive: assert property (@(posedge clk) disable iff (rst)
        !(bus.refill && bus.store))
        else $error("refill and store strobes high together");

endmodule

// File: logic/cacheArrayIf.sv
`timescale 1ns/10ps

interface cacheArrayIf;
    import cacheGeomPkg::*;

    addrT lookupAddr;  // also the refill and store address
    logic hit;
    wayT hitWay;
    dataT hitData;

    logic refill;
    dataT refillData;

    logic store;
    dataT storeData;
    maskT storeMask;

    modport ctrl (
        output lookupAddr, refill, refillData, store, storeData, storeMask,
        input hit, hitWay, hitData
    );

    modport array (
        input lookupAddr, refill, refillData, store, storeData, storeMask,
        output hit, hitWay, hitData
    );

endinterface

// File: logic/cacheController.sv
`timescale 1ns/10ps

module cacheController (
    input logic clk,
    input logic rst,
    input logic reqValid,
    input logic reqWrite,
    input cacheGeomPkg::addrT reqAddr,
    input cacheGeomPkg::dataT reqWData,
    input cacheGeomPkg::maskT reqMask,
    output logic reqReady,
    output logic respValid,
    output cacheGeomPkg::dataT respRData,
    output logic respError,
    cacheArrayIf.ctrl arr,
    memReqIf.client mem
);
    import cacheGeomPkg::*;
    import busCtrlPkg::*;

    ctrlStateT state;

    logic curWrite;
    addrT curAddr;
    dataT curWData;
    maskT curMask;
    dataT rdataQ;
    logic errQ;

    assign reqReady = (state == ctrlIdle);
    assign respValid = (state == ctrlRespond);
    assign respRData = rdataQ;
    assign respError = errQ;

    assign arr.lookupAddr = curAddr;
    assign arr.store = (state == ctrlCheck) && curWrite && arr.hit;  // no allocate on store miss
    assign arr.storeData = curWData;
    assign arr.storeMask = curMask;
    assign arr.refill = (state == ctrlMemWait) && mem.done && !curWrite && !mem.error;
    assign arr.refillData = mem.rdata;

    // write-through and load misses both go out on the bus
    assign mem.valid = (state == ctrlMemWait);
    assign mem.write = curWrite;
    assign mem.addr = curAddr;
    assign mem.wdata = curWData;
    assign mem.strb = curMask;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ctrlIdle;
        end else begin
            case (state)
                ctrlIdle: if (reqValid) state <= ctrlCheck;
                ctrlCheck: state <= (!curWrite && arr.hit) ? ctrlRespond : ctrlMemWait;
                ctrlMemWait: if (mem.done) state <= ctrlRespond;
                ctrlRespond: state <= ctrlIdle;
                default: state <= ctrlIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            curAddr <= '0;
        end else if (reqValid && reqReady) begin
            curWrite <= reqWrite;
            curAddr <= reqAddr;
            curWData <= reqWData;
            curMask <= reqMask;
        end
        if (state == ctrlCheck) begin
            rdataQ <= arr.hitData;
            errQ <= 1'b0;
        end
        if (mem.done) begin
            rdataQ <= mem.rdata;
            errQ <= mem.error;
        end
    end

    // one request in flight: no new acceptance before the response
    oneInFlight: assert property (@(posedge clk) disable iff (rst)
        (reqValid && reqReady) |=> (!reqReady throughout respValid[->1]))
        else $error("request accepted while another is in flight");

    respPulse: assert property (@(posedge clk) disable iff (rst)
        respValid |=> !respValid)
        else $error("respValid held longer than one cycle");

endmodule

// File: logic/cacheGeomPkg.sv
package cacheGeomPkg;

    `include "cache_defines.svh"

    localparam int offW = $clog2(`BYTES_W);  // byte offset inside a word
    localparam int idxW = $clog2(`NUM_SETS);
    localparam int tagW = `ADDR_W - idxW - offW;

    typedef logic [`ADDR_W-1:0] addrT;
    typedef logic [`DATA_W-1:0] dataT;
    typedef logic [tagW-1:0] tagT;
    typedef logic [idxW-1:0] indexT;
    typedef logic [`BYTES_W-1:0] maskT;
    typedef logic [$clog2(`NUM_WAYS)-1:0] wayT;

endpackage

// File: logic/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// byte address width, sized for the APB address bus
`define ADDR_W 32

`define DATA_W 64
`define NUM_SETS 4
`define NUM_WAYS 2 // one victim bit per set only covers two ways
`define BYTES_W 8

`endif

// File: logic/dataCacheTop.sv
`timescale 1ns/10ps

module dataCacheTop (
    input logic clk,
    input logic rst,

    // CPU side
    input logic reqValid,
    input logic reqWrite,
    input cacheGeomPkg::addrT reqAddr,
    input cacheGeomPkg::dataT reqWData,
    input cacheGeomPkg::maskT reqMask,
    output logic reqReady,
    output logic respValid,
    output cacheGeomPkg::dataT respRData,
    output logic respError,

    // APB side
    output logic psel,
    output logic penable,
    output logic pwrite,
    output cacheGeomPkg::addrT paddr,
    output cacheGeomPkg::dataT pwdata,
    output cacheGeomPkg::maskT pstrb,
    input cacheGeomPkg::dataT prdata,
    input logic pready,
    input logic pslverr
);

    cacheArrayIf arrBus ();
    memReqIf memBus ();

    cacheArray u_array (
        .clk (clk),
        .rst (rst),
        .bus (arrBus.array)
    );

    cacheController u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .reqValid  (reqValid),
        .reqWrite  (reqWrite),
        .reqAddr   (reqAddr),
        .reqWData  (reqWData),
        .reqMask   (reqMask),
        .reqReady  (reqReady),
        .respValid (respValid),
        .respRData (respRData),
        .respError (respError),
        .arr       (arrBus.ctrl),
        .mem       (memBus.client)
    );

    apbRequester u_apb (
        .clk     (clk),
        .rst     (rst),
        .mem     (memBus.server),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

endmodule

// File: logic/memReqIf.sv
`timescale 1ns/10ps

interface memReqIf;
    import cacheGeomPkg::*;

    logic valid;  // held until done
    logic write;
    addrT addr;
    dataT wdata;
    maskT strb;

    logic done;   // single cycle
    dataT rdata;
    logic error;

    modport client (
        output valid, write, addr, wdata, strb,
        input done, rdata, error
    );

    modport server (
        input valid, write, addr, wdata, strb,
        output done, rdata, error
    );

endinterface
